// File: common/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// Dot and line timing
`define LCD_DOT_DIVIDE        8
`define LCD_DOTS_PER_LINE     456
`define LCD_LINES             154
`define LCD_VISIBLE_LINES     144
`define LCD_VISIBLE_PIXELS    160
`define LCD_OAM_DOTS          80
`define LCD_XFER_DOTS         172

// Mode codes as seen in STAT[1:0]
`define LCD_MODE_HBLANK       2'd0
`define LCD_MODE_VBLANK       2'd1
`define LCD_MODE_OAM          2'd2
`define LCD_MODE_XFER         2'd3

// CPU register addresses
`define LCD_ADDR_LCDC         16'hFF40
`define LCD_ADDR_STAT         16'hFF41
`define LCD_ADDR_SCY          16'hFF42
`define LCD_ADDR_SCX          16'hFF43
`define LCD_ADDR_LY           16'hFF44
`define LCD_ADDR_LYC          16'hFF45
`define LCD_ADDR_BGP          16'hFF47

// VRAM window in CPU space and bases inside VRAM
`define LCD_VRAM_BASE         16'h8000
`define LCD_VRAM_LIMIT        16'hA000
`define LCD_MAP0_BASE         13'h1800
`define LCD_MAP1_BASE         13'h1C00
`define LCD_TILES_SIGNED_BASE 13'h1000

`endif

// File: common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

   // One tile map byte, read two ways
   // LCDC[4] set selects the unsigned view, tiles from 8000
   // LCDC[4] clear selects the signed view, tiles around 9000
   typedef union packed {
      logic [7:0]        tile_unsigned;
      logic signed [7:0] tile_signed;
   } tile_index_u;

endpackage

`default_nettype wire

// File: common/lcd_regs_if.sv
`timescale 1ns/100ps
`default_nettype none

// Register values shared by the register block, timing and renderer
interface lcd_regs_if;

   // LCD control
   logic [7:0] lcdc;
   // STAT interrupt selects, bits 6 to 3 of STAT
   logic [3:0] stat_select;
   // Background scroll
   logic [7:0] scy;
   logic [7:0] scx;
   // Line compare
   logic [7:0] lyc;
   // Background palette
   logic [7:0] bgp;

   // Register file drives everything
   modport owner (output lcdc, stat_select, scy, scx, lyc, bgp);

   // Timing needs enable, compare and interrupt selects
   modport timing (input lcdc, stat_select, lyc);

   // Renderer needs map and data selects, scroll and palette
   modport render (input lcdc, scy, scx, bgp);

endinterface

`default_nettype wire

// File: render/vram.sv
`timescale 1ns/100ps
`default_nettype none

// 8 KiB video RAM, registered reads on both ports
module vram #(
   parameter int ADDR_W = 13
) (
   input  logic              clock,
   // CPU side, read and write
   input  logic [ADDR_W-1:0] a_addr,
   input  logic              a_we,
   input  logic [7:0]        a_wr_data,
   output logic [7:0]        a_rd_data,
   // Renderer side, read only
   input  logic [ADDR_W-1:0] b_addr,
   output logic [7:0]        b_rd_data
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [7:0] mem [0:DEPTH-1];

   // Read returns the old byte on a same-address write
   always_ff @(posedge clock) begin
      if (a_we) mem[a_addr] <= a_wr_data;
      a_rd_data <= mem[a_addr];
   end

   always_ff @(posedge clock) begin
      b_rd_data <= mem[b_addr];
   end

endmodule

`default_nettype wire

// File: render/bg_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module bg_fetch (
   input  logic        clock,
   input  logic        reset,
   lcd_regs_if.render  regs,
   input  logic        line_start,
   input  logic [7:0]  line_count,
   output logic [12:0] vram_addr,
   input  logic [7:0]  vram_rd_data,
   output logic [7:0]  pixel_x,
   output logic [1:0]  pixel_shade,
   output logic        pixel_we
);

   // Fetch FSM states
   localparam logic [2:0] S_IDLE = 3'd0;
   localparam logic [2:0] S_MAP  = 3'd1;
   localparam logic [2:0] S_LOW  = 3'd2;
   localparam logic [2:0] S_HIGH = 3'd3;
   localparam logic [2:0] S_LOAD = 3'd4;
   localparam logic [2:0] S_PIX  = 3'd5;

   logic [2:0]         state;
   logic [7:0]         row_y;
   logic [4:0]         coarse_x;
   logic [4:0]         tile_col;
   logic [4:0]         map_col;
   logic [2:0]         discard;
   logic [2:0]         bit_count;
   logic [7:0]         px_count;
   logic [7:0]         shift_lo;
   logic [7:0]         shift_hi;
   logic [12:0]        map_base;
   logic [12:0]        map_addr;
   logic [12:0]        row_offset;
   logic [12:0]        plane_addr;
   logic [12:0]        plane_addr_q;
   logic signed [12:0] tile_signed_ext;
   lcd_pkg::tile_index_u tile_index;
   logic [1:0]         color_index;
   logic               emit;

   //////////////////////////////////////////////////
   // VRAM addressing
   //////////////////////////////////////////////////

   // 32x32 map, coarse x wraps at 32 tiles
   assign map_base = regs.lcdc[3] ? `LCD_MAP1_BASE : `LCD_MAP0_BASE;
   assign map_col  = coarse_x + tile_col;
   assign map_addr = map_base + {3'b000, row_y[7:3], map_col};

   // Map byte arrives in S_LOW
   assign tile_index      = vram_rd_data;
   assign tile_signed_ext = tile_index.tile_signed;
   // Two bytes per tile row
   assign row_offset      = {9'd0, row_y[2:0], 1'b0};
   assign plane_addr = regs.lcdc[4] ?
                       {1'b0, tile_index.tile_unsigned, 4'b0000} + row_offset :
                       `LCD_TILES_SIGNED_BASE + (tile_signed_ext <<< 4) + row_offset;

   always_comb begin
      case (state)
         S_MAP:   vram_addr = map_addr;
         S_LOW:   vram_addr = plane_addr;
         // High plane byte follows the low one
         default: vram_addr = {plane_addr_q[12:1], 1'b1};
      endcase
   end

   //////////////////////////////////////////////////
   // Fetch FSM
   //////////////////////////////////////////////////

   assign emit = (state == S_PIX) && (discard == 3'd0);

   always_ff @(posedge clock) begin
      if (reset || !regs.lcdc[7]) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: if (line_start) state <= S_MAP;
            S_MAP:  state <= S_LOW;
            S_LOW:  state <= S_HIGH;
            S_HIGH: state <= S_LOAD;
            S_LOAD: state <= S_PIX;
            S_PIX: begin
               // Line ends after the last visible pixel, at most 21 tiles
               if (emit && px_count == 8'(`LCD_VISIBLE_PIXELS - 1))
                  state <= S_IDLE;
               else if (bit_count == 3'd7)
                  state <= S_MAP;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      case (state)
         S_IDLE: begin
            // Scroll sampled once per line
            row_y    <= regs.scy + line_count;
            coarse_x <= regs.scx[7:3];
            discard  <= regs.scx[2:0];
            tile_col <= 5'd0;
            px_count <= 8'd0;
         end
         S_LOW:  plane_addr_q <= plane_addr;
         S_HIGH: shift_lo <= vram_rd_data;
         S_LOAD: begin
            shift_hi  <= vram_rd_data;
            bit_count <= 3'd0;
         end
         S_PIX: begin
            // Leftmost pixel in bit 7
            shift_lo  <= shift_lo << 1;
            shift_hi  <= shift_hi << 1;
            bit_count <= bit_count + 3'd1;
            if (bit_count == 3'd7) tile_col <= tile_col + 5'd1;
            // Fine scroll drops pixels before counting
            if (discard != 3'd0) discard <= discard - 3'd1;
            else px_count <= px_count + 8'd1;
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////
   // Palette output stage
   //////////////////////////////////////////////////

   assign color_index = regs.lcdc[0] ? {shift_hi[7], shift_lo[7]} : 2'b00;

   always_ff @(posedge clock) begin
      if (reset) pixel_we <= 1'b0;
      else pixel_we <= emit;
   end

   always_ff @(posedge clock) begin
      if (emit) begin
         pixel_x     <= px_count;
         pixel_shade <= regs.bgp[{color_index, 1'b0} +: 2];
      end
   end

endmodule

`default_nettype wire

// File: src/lcd_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_regs (
   input  logic        clock,
   input  logic        reset,
   input  logic        mem_enable,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [15:0] addr,
   input  logic [7:0]  wr_data,
   output logic [7:0]  rd_data,
   lcd_regs_if.owner   regs,
   input  logic [1:0]  mode,
   input  logic [7:0]  line_count,
   output logic [12:0] cpu_vram_addr,
   output logic        cpu_vram_we,
   output logic [7:0]  cpu_vram_wr_data,
   input  logic [7:0]  cpu_vram_rd_data
);

   logic [7:0] lcdc;
   logic [3:0] stat_select;
   logic [7:0] scy;
   logic [7:0] scx;
   logic [7:0] lyc;
   logic [7:0] bgp;
   logic [7:0] stat;
   logic       vram_sel;
   logic       vram_locked;
   logic       bus_rd;
   logic       bus_wr;
   logic [7:0] reg_rd_data;
   logic [7:0] rd_reg_q;
   logic       rd_vram_q;

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   assign bus_rd      = mem_enable && !rd_n;
   assign bus_wr      = mem_enable && !wr_n;
   assign vram_sel    = (addr >= `LCD_VRAM_BASE) && (addr < `LCD_VRAM_LIMIT);
   // Renderer owns VRAM during transfer
   assign vram_locked = (mode == `LCD_MODE_XFER);

   // CPU port of VRAM
   assign cpu_vram_addr    = 13'(addr - `LCD_VRAM_BASE);
   assign cpu_vram_we      = bus_wr && vram_sel && !vram_locked;
   assign cpu_vram_wr_data = wr_data;

   //////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         lcdc        <= 8'hE3;
         stat_select <= 4'h0;
         scy         <= 8'h00;
         scx         <= 8'h00;
         lyc         <= 8'h00;
         bgp         <= 8'hE4;
      end else if (bus_wr) begin
         // LY and unmapped addresses fall through
         case (addr)
            `LCD_ADDR_LCDC: lcdc <= wr_data;
            `LCD_ADDR_STAT: stat_select <= wr_data[6:3];
            `LCD_ADDR_SCY:  scy <= wr_data;
            `LCD_ADDR_SCX:  scx <= wr_data;
            `LCD_ADDR_LYC:  lyc <= wr_data;
            `LCD_ADDR_BGP:  bgp <= wr_data;
            default: ;
         endcase
      end
   end

   assign regs.lcdc        = lcdc;
   assign regs.stat_select = stat_select;
   assign regs.scy         = scy;
   assign regs.scx         = scx;
   assign regs.lyc         = lyc;
   assign regs.bgp         = bgp;

   // Bit 7 unused, then selects, coincidence, mode
   assign stat = {1'b0, stat_select, line_count == lyc, mode};

   //////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////

   always_comb begin
      case (addr)
         `LCD_ADDR_LCDC: reg_rd_data = lcdc;
         `LCD_ADDR_STAT: reg_rd_data = stat;
         `LCD_ADDR_SCY:  reg_rd_data = scy;
         `LCD_ADDR_SCX:  reg_rd_data = scx;
         `LCD_ADDR_LY:   reg_rd_data = line_count;
         `LCD_ADDR_LYC:  reg_rd_data = lyc;
         `LCD_ADDR_BGP:  reg_rd_data = bgp;
         // Unmapped, and locked VRAM
         default:        reg_rd_data = 8'hFF;
      endcase
   end

   // VRAM data is already registered inside the RAM
   always_ff @(posedge clock) begin
      if (reset) begin
         rd_vram_q <= 1'b0;
      end else if (bus_rd) begin
         rd_vram_q <= vram_sel && !vram_locked;
      end
   end

   always_ff @(posedge clock) begin
      if (bus_rd) begin
         rd_reg_q <= reg_rd_data;
      end
   end

   assign rd_data = rd_vram_q ? cpu_vram_rd_data : rd_reg_q;

endmodule

`default_nettype wire

// File: src/lcd_timing.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_timing (
   input  logic       clock,
   input  logic       reset,
   lcd_regs_if.timing regs,
   input  logic       int_vblank_ack,
   input  logic       int_lcdc_ack,
   output logic       int_vblank_req,
   output logic       int_lcdc_req,
   output logic [1:0] mode,
   output logic [7:0] line_count,
   output logic       line_start,
   output logic       hsync,
   output logic       vsync
);

   localparam int DIV_W = $clog2(`LCD_DOT_DIVIDE);

   logic [DIV_W-1:0] div_count;
   logic             dot_tick;
   logic [8:0]       dot_count;
   logic             display_on;
   logic [1:0]       mode_next;
   logic             mode_entry;
   logic             lyc_hit;
   logic             lcdc_set;

   assign display_on = regs.lcdc[7];

   //////////////////////////////////////////////////
   // Dot divider and counters
   //////////////////////////////////////////////////

   assign dot_tick = display_on && (div_count == DIV_W'(`LCD_DOT_DIVIDE - 1));

   always_ff @(posedge clock) begin
      if (reset || !display_on || dot_tick) begin
         div_count <= '0;
      end else begin
         div_count <= div_count + 1'b1;
      end
   end

   // Held at zero while the LCD is off
   always_ff @(posedge clock) begin
      if (reset || !display_on) begin
         dot_count  <= 9'd0;
         line_count <= 8'd0;
      end else if (dot_tick) begin
         if (dot_count == 9'(`LCD_DOTS_PER_LINE - 1)) begin
            dot_count  <= 9'd0;
            line_count <= (line_count == 8'(`LCD_LINES - 1)) ? 8'd0 : line_count + 8'd1;
         end else begin
            dot_count <= dot_count + 9'd1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Mode and events
   //////////////////////////////////////////////////

   always_comb begin
      if (!display_on)
         mode_next = `LCD_MODE_HBLANK;
      else if (line_count >= 8'(`LCD_VISIBLE_LINES))
         mode_next = `LCD_MODE_VBLANK;
      else if (dot_count < 9'(`LCD_OAM_DOTS))
         mode_next = `LCD_MODE_OAM;
      else if (dot_count < 9'(`LCD_OAM_DOTS + `LCD_XFER_DOTS))
         mode_next = `LCD_MODE_XFER;
      else
         mode_next = `LCD_MODE_HBLANK;
   end

   // One clock wide
   assign mode_entry = display_on && (mode_next != mode);
   // First clock of dot 0 only
   assign lyc_hit = display_on && (div_count == '0) && (dot_count == 9'd0) &&
                    (line_count == regs.lyc);

   // Select bits 0..3 are STAT bits 3..6
   assign lcdc_set = (mode_entry && mode_next == `LCD_MODE_HBLANK && regs.stat_select[0]) ||
                     (mode_entry && mode_next == `LCD_MODE_VBLANK && regs.stat_select[1]) ||
                     (mode_entry && mode_next == `LCD_MODE_OAM && regs.stat_select[2]) ||
                     (lyc_hit && regs.stat_select[3]);

   always_ff @(posedge clock) begin
      if (reset) begin
         mode           <= `LCD_MODE_HBLANK;
         line_start     <= 1'b0;
         int_vblank_req <= 1'b0;
         int_lcdc_req   <= 1'b0;
      end else begin
         mode       <= mode_next;
         line_start <= mode_entry && (mode_next == `LCD_MODE_XFER);
         // New request wins over ack
         if (mode_entry && mode_next == `LCD_MODE_VBLANK)
            int_vblank_req <= 1'b1;
         else if (int_vblank_ack)
            int_vblank_req <= 1'b0;
         if (lcdc_set)
            int_lcdc_req <= 1'b1;
         else if (int_lcdc_ack)
            int_lcdc_req <= 1'b0;
      end
   end

   // Sync after the visible part of line and frame
   assign hsync = dot_count > 9'(`LCD_OAM_DOTS + `LCD_XFER_DOTS + `LCD_VISIBLE_PIXELS);
   assign vsync = line_count > 8'(`LCD_VISIBLE_LINES);

endmodule

`default_nettype wire

// File: src/lcd_top.sv
`timescale 1ns/100ps
`default_nettype none

module lcd_top (
   input  logic        clock,
   input  logic        reset,
   // CPU bus
   input  logic        mem_enable,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [15:0] addr,
   input  logic [7:0]  wr_data,
   output logic [7:0]  rd_data,
   // Interrupt controller
   input  logic        int_vblank_ack,
   input  logic        int_lcdc_ack,
   output logic        int_vblank_req,
   output logic        int_lcdc_req,
   // Display
   output logic        hsync,
   output logic        vsync,
   output logic [7:0]  line_count,
   output logic [7:0]  pixel_x,
   output logic [1:0]  pixel_shade,
   output logic        pixel_we
);

   logic [1:0]  mode;
   logic        line_start;
   logic [12:0] cpu_vram_addr;
   logic        cpu_vram_we;
   logic [7:0]  cpu_vram_wr_data;
   logic [7:0]  cpu_vram_rd_data;
   logic [12:0] render_vram_addr;
   logic [7:0]  render_vram_rd_data;

   lcd_regs_if u_regs_if ();

   // Decode and register file
   lcd_regs u_regs (
      .clock(clock), .reset(reset),
      .mem_enable(mem_enable), .rd_n(rd_n), .wr_n(wr_n),
      .addr(addr), .wr_data(wr_data), .rd_data(rd_data),
      .regs(u_regs_if.owner), .mode(mode), .line_count(line_count),
      .cpu_vram_addr(cpu_vram_addr), .cpu_vram_we(cpu_vram_we),
      .cpu_vram_wr_data(cpu_vram_wr_data), .cpu_vram_rd_data(cpu_vram_rd_data)
   );

   // Dot and line counters, mode, interrupts
   lcd_timing u_timing (
      .clock(clock), .reset(reset), .regs(u_regs_if.timing),
      .int_vblank_ack(int_vblank_ack), .int_lcdc_ack(int_lcdc_ack),
      .int_vblank_req(int_vblank_req), .int_lcdc_req(int_lcdc_req),
      .mode(mode), .line_count(line_count), .line_start(line_start),
      .hsync(hsync), .vsync(vsync)
   );

   // Background renderer
   bg_fetch u_bg_fetch (
      .clock(clock), .reset(reset), .regs(u_regs_if.render),
      .line_start(line_start), .line_count(line_count),
      .vram_addr(render_vram_addr), .vram_rd_data(render_vram_rd_data),
      .pixel_x(pixel_x), .pixel_shade(pixel_shade), .pixel_we(pixel_we)
   );

   // Port a for the CPU, port b for the renderer
   vram u_vram (
      .clock(clock),
      .a_addr(cpu_vram_addr), .a_we(cpu_vram_we),
      .a_wr_data(cpu_vram_wr_data), .a_rd_data(cpu_vram_rd_data),
      .b_addr(render_vram_addr), .b_rd_data(render_vram_rd_data)
   );

endmodule

`default_nettype wire

// File: tests/lcd_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "lcd_config.svh"

module lcd_tb;

   // Clocks to wait for a line or an interrupt, a little over one frame
   localparam int FRAME_LIMIT = 600000;
   localparam int LINE_CLOCKS = `LCD_DOT_DIVIDE * `LCD_DOTS_PER_LINE;
   // Clocks from line start to the first hsync dot, dot 413
   localparam int HSYNC_CLOCKS = 413 * `LCD_DOT_DIVIDE;
   // Line used for the pixel capture
   localparam logic [7:0] CAPTURE_LINE = 8'd3;

   logic        clock;
   logic        reset;
   logic        mem_enable;
   logic        rd_n;
   logic        wr_n;
   logic [15:0] addr;
   logic [7:0]  wr_data;
   logic [7:0]  rd_data;
   logic        int_vblank_ack;
   logic        int_lcdc_ack;
   logic        int_vblank_req;
   logic        int_lcdc_req;
   logic        hsync;
   logic        vsync;
   logic [7:0]  line_count;
   logic [7:0]  pixel_x;
   logic [1:0]  pixel_shade;
   logic        pixel_we;

   int          error_count;
   logic [31:0] lcg_state;
   // Copy of VRAM contents for the pixel model
   logic [7:0]  vram_model [0:8191];

   lcd_top u_dut (
      .clock(clock), .reset(reset),
      .mem_enable(mem_enable), .rd_n(rd_n), .wr_n(wr_n),
      .addr(addr), .wr_data(wr_data), .rd_data(rd_data),
      .int_vblank_ack(int_vblank_ack), .int_lcdc_ack(int_lcdc_ack),
      .int_vblank_req(int_vblank_req), .int_lcdc_req(int_lcdc_req),
      .hsync(hsync), .vsync(vsync), .line_count(line_count),
      .pixel_x(pixel_x), .pixel_shade(pixel_shade), .pixel_we(pixel_we)
   );

   initial clock = 1'b0;
   // 40 ns period
   always #20 clock = ~clock;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [7:0] rand_byte();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[23:16];
   endfunction

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         error_count++;
         $display("error %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // Write lands on the second edge
   task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
      @(posedge clock);
      mem_enable <= 1'b1;
      wr_n       <= 1'b0;
      addr       <= a;
      wr_data    <= d;
      @(posedge clock);
      mem_enable <= 1'b0;
      wr_n       <= 1'b1;
   endtask

   // Data valid in the cycle after the sampling edge
   task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
      @(posedge clock);
      mem_enable <= 1'b1;
      rd_n       <= 1'b0;
      addr       <= a;
      @(posedge clock);
      mem_enable <= 1'b0;
      rd_n       <= 1'b1;
      @(negedge clock);
      d = rd_data;
   endtask

   // Returns the number of clocks until LY showed the target
   task automatic wait_for_line(input logic [7:0] target, output int waited);
      int n;
      @(negedge clock);
      n = 1;
      while (line_count !== target && n < FRAME_LIMIT) begin
         @(negedge clock);
         n++;
      end
      if (line_count !== target) begin
         error_count++;
         $display("timeout: LY never reached %0d", target);
      end
      waited = n;
   endtask

   // Polls STAT until the mode field matches
   task automatic wait_for_mode(input logic [1:0] target);
      logic [7:0] d;
      int         n;
      n = 0;
      bus_read(`LCD_ADDR_STAT, d);
      while (d[1:0] !== target && n < 3000) begin
         bus_read(`LCD_ADDR_STAT, d);
         n++;
      end
      if (d[1:0] !== target) begin
         error_count++;
         $display("timeout: STAT never showed mode %0d", target);
      end
   endtask

   // Either request line, selected by the flag
   task automatic wait_for_request(input bit lcdc_line);
      int n;
      @(negedge clock);
      n = 1;
      while (!(lcdc_line ? int_lcdc_req : int_vblank_req) && n < FRAME_LIMIT) begin
         @(negedge clock);
         n++;
      end
      if (!(lcdc_line ? int_lcdc_req : int_vblank_req)) begin
         error_count++;
         $display("timeout: interrupt request %0s never rose",
                  lcdc_line ? "lcdc" : "vblank");
      end
   endtask

   task automatic pulse_acks();
      @(posedge clock);
      int_vblank_ack <= 1'b1;
      int_lcdc_ack   <= 1'b1;
      @(posedge clock);
      int_vblank_ack <= 1'b0;
      int_lcdc_ack   <= 1'b0;
      @(negedge clock);
   endtask

   // Background pixel from the VRAM copy and register values
   function automatic logic [1:0] model_shade(input int x, input logic [7:0] ly,
                                              input logic [7:0] lcdc_v,
                                              input logic [7:0] scx_v,
                                              input logic [7:0] scy_v,
                                              input logic [7:0] bgp_v);
      logic [7:0]           px;
      logic [7:0]           py;
      int                   map_addr;
      int                   tile_addr;
      int                   bit_pos;
      logic [1:0]           idx;
      lcd_pkg::tile_index_u tile;
      px = scx_v + 8'(x);
      py = scy_v + ly;
      // 32 tiles per map row
      map_addr = (lcdc_v[3] ? `LCD_MAP1_BASE : `LCD_MAP0_BASE)
                 + 32 * int'(py[7:3]) + int'(px[7:3]);
      tile = vram_model[map_addr];
      if (lcdc_v[4])
         tile_addr = 16 * int'(tile.tile_unsigned);
      else
         tile_addr = `LCD_TILES_SIGNED_BASE + 16 * int'(tile.tile_signed);
      tile_addr = tile_addr + 2 * int'(py[2:0]);
      // Leftmost pixel is bit 7
      bit_pos = 7 - int'(px[2:0]);
      idx = {vram_model[tile_addr + 1][bit_pos], vram_model[tile_addr][bit_pos]};
      if (!lcdc_v[0])
         idx = 2'b00;
      return bgp_v[2 * idx +: 2];
   endfunction

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic test_registers();
      logic [7:0] d;
      logic [7:0] w;
      logic [7:0] lyc_w;
      bus_read(`LCD_ADDR_LCDC, d);
      check_equal("reset lcdc", 8'hE3, d);
      bus_read(`LCD_ADDR_SCY, d);
      check_equal("reset scy", 8'h00, d);
      bus_read(`LCD_ADDR_SCX, d);
      check_equal("reset scx", 8'h00, d);
      bus_read(`LCD_ADDR_LYC, d);
      check_equal("reset lyc", 8'h00, d);
      bus_read(`LCD_ADDR_BGP, d);
      check_equal("reset bgp", 8'hE4, d);
      bus_read(`LCD_ADDR_LY, d);
      check_equal("reset ly", 8'h00, d);
      // Selects clear, LY equals LYC, mode still moving
      bus_read(`LCD_ADDR_STAT, d);
      check_equal("reset stat", 8'h04, d & 8'hFC);
      // Display off for the rest
      w = rand_byte() & 8'h7F;
      bus_write(`LCD_ADDR_LCDC, w);
      bus_read(`LCD_ADDR_LCDC, d);
      check_equal("lcdc readback", w, d);
      bus_write(`LCD_ADDR_LCDC, 8'h00);
      w = rand_byte();
      bus_write(`LCD_ADDR_SCY, w);
      bus_read(`LCD_ADDR_SCY, d);
      check_equal("scy readback", w, d);
      w = rand_byte();
      bus_write(`LCD_ADDR_SCX, w);
      bus_read(`LCD_ADDR_SCX, d);
      check_equal("scx readback", w, d);
      lyc_w = rand_byte();
      bus_write(`LCD_ADDR_LYC, lyc_w);
      bus_read(`LCD_ADDR_LYC, d);
      check_equal("lyc readback", lyc_w, d);
      w = rand_byte();
      bus_write(`LCD_ADDR_BGP, w);
      bus_read(`LCD_ADDR_BGP, d);
      check_equal("bgp readback", w, d);
      // LY is read only
      bus_write(`LCD_ADDR_LY, rand_byte() | 8'h01);
      bus_read(`LCD_ADDR_LY, d);
      check_equal("ly write ignored", 8'h00, d);
      // Mode 0 with the display off
      w = rand_byte();
      bus_write(`LCD_ADDR_STAT, w);
      bus_read(`LCD_ADDR_STAT, d);
      check_equal("stat readback", {1'b0, w[6:3], lyc_w == 8'h00, 2'b00}, d);
      bus_write(`LCD_ADDR_LYC, 8'h00);
      bus_read(`LCD_ADDR_STAT, d);
      check_equal("stat coincidence", {1'b0, w[6:3], 1'b1, 2'b00}, d);
      bus_write(`LCD_ADDR_STAT, 8'h00);
      bus_read(16'hFF46, d);
      check_equal("unmapped read", 8'hFF, d);
   endtask

   task automatic test_vram();
      logic [7:0]  data [0:63];
      logic [7:0]  d;
      logic [15:0] a;
      bus_write(`LCD_ADDR_LCDC, 8'h00);
      // Spread over the whole 8 KiB
      for (int i = 0; i < 64; i++) begin
         data[i] = rand_byte();
         a = `LCD_VRAM_BASE + 16'(i * 128 + i);
         bus_write(a, data[i]);
      end
      for (int i = 0; i < 64; i++) begin
         a = `LCD_VRAM_BASE + 16'(i * 128 + i);
         bus_read(a, d);
         check_equal($sformatf("vram readback %0h", a), data[i], d);
      end
      // Locked during transfer
      bus_write(`LCD_ADDR_LCDC, 8'h80);
      wait_for_mode(`LCD_MODE_XFER);
      bus_read(`LCD_VRAM_BASE, d);
      check_equal("vram locked read", 8'hFF, d);
      bus_write(`LCD_VRAM_BASE, ~data[0]);
      bus_write(`LCD_ADDR_LCDC, 8'h00);
      bus_read(`LCD_VRAM_BASE, d);
      check_equal("vram locked write", data[0], d);
   endtask

   task automatic test_line_timing();
      logic [7:0] d;
      int         n;
      bus_write(`LCD_ADDR_LCDC, 8'h80);
      wait_for_line(8'd1, n);
      wait_for_line(8'd2, n);
      check_equal("line length", LINE_CLOCKS, n);
      // hsync rises late in the line
      n = 0;
      while (!hsync && n < LINE_CLOCKS) begin
         @(negedge clock);
         n++;
      end
      if (!hsync) begin
         error_count++;
         $display("timeout: hsync never rose");
      end
      check_equal("hsync start", HSYNC_CLOCKS, n);
      for (int l = 3; l < `LCD_LINES; l++) begin
         wait_for_line(8'(l), n);
         check_equal($sformatf("vsync line %0d", l), l > 144, vsync);
         check_equal($sformatf("hsync line %0d", l), 1'b0, hsync);
         bus_read(`LCD_ADDR_LY, d);
         check_equal("ly step", l, d);
         // Early in the line, so OAM search when visible
         bus_read(`LCD_ADDR_STAT, d);
         check_equal($sformatf("stat mode line %0d", l), l >= 144 ? 1 : 2, d[1:0]);
      end
      // Wrap to line 0
      wait_for_line(8'd0, n);
      check_equal("vsync after wrap", 1'b0, vsync);
      bus_read(`LCD_ADDR_LY, d);
      check_equal("ly wrap", 8'h00, d);
   endtask

   task automatic test_interrupts();
      bus_write(`LCD_ADDR_LCDC, 8'h00);
      bus_write(`LCD_ADDR_STAT, 8'h00);
      bus_write(`LCD_ADDR_LYC, 8'd5);
      pulse_acks();
      check_equal("vblank req cleared", 1'b0, int_vblank_req);
      check_equal("lcdc req cleared", 1'b0, int_lcdc_req);
      bus_write(`LCD_ADDR_LCDC, 8'h80);
      wait_for_request(1'b0);
      check_equal("vblank req line", 8'd144, line_count);
      // Past line 5 and many mode entries with no select
      check_equal("lcdc req no select", 1'b0, int_lcdc_req);
      pulse_acks();
      check_equal("vblank req after ack", 1'b0, int_vblank_req);
      // LYC compare only
      bus_write(`LCD_ADDR_STAT, 8'h40);
      wait_for_request(1'b1);
      check_equal("lcdc req line", 8'd5, line_count);
      pulse_acks();
      check_equal("lcdc req after ack", 1'b0, int_lcdc_req);
      bus_write(`LCD_ADDR_STAT, 8'h00);
   endtask

   task automatic capture_line(input logic [7:0] lcdc_v, input logic [7:0] scx_v,
                               input logic [7:0] scy_v, input logic [7:0] bgp_v);
      int count;
      int guard;
      int n;
      wait_for_line(CAPTURE_LINE, n);
      count = 0;
      guard = 0;
      while (line_count == CAPTURE_LINE && guard < LINE_CLOCKS + 100) begin
         if (pixel_we) begin
            if (count < `LCD_VISIBLE_PIXELS) begin
               check_equal("pixel x", count, pixel_x);
               check_equal($sformatf("pixel shade lcdc %0h x %0d", lcdc_v, count),
                           model_shade(count, CAPTURE_LINE, lcdc_v, scx_v, scy_v, bgp_v),
                           pixel_shade);
               if (!lcdc_v[0])
                  check_equal("pixel shade bg off", bgp_v[1:0], pixel_shade);
            end
            count++;
         end
         @(negedge clock);
         guard++;
      end
      if (line_count == CAPTURE_LINE) begin
         error_count++;
         $display("timeout: capture line did not end");
      end
      check_equal("pixel count", `LCD_VISIBLE_PIXELS, count);
   endtask

   task automatic test_background();
      logic [7:0] cfg;
      logic [7:0] scx_v;
      logic [7:0] scy_v;
      logic [7:0] bgp_v;
      bus_write(`LCD_ADDR_LCDC, 8'h00);
      // Maps and tile data from the LCG
      for (int i = 0; i < 8192; i++) begin
         vram_model[i] = rand_byte();
         bus_write(`LCD_VRAM_BASE + 16'(i), vram_model[i]);
      end
      // Unsigned map 0, signed map 1, then background off
      for (int k = 0; k < 3; k++) begin
         cfg   = (k == 0) ? 8'h91 : (k == 1) ? 8'h89 : 8'h98;
         scx_v = rand_byte();
         scy_v = rand_byte();
         bgp_v = rand_byte();
         bus_write(`LCD_ADDR_LCDC, 8'h00);
         bus_write(`LCD_ADDR_SCX, scx_v);
         bus_write(`LCD_ADDR_SCY, scy_v);
         bus_write(`LCD_ADDR_BGP, bgp_v);
         bus_write(`LCD_ADDR_LCDC, cfg);
         capture_line(cfg, scx_v, scy_v, bgp_v);
      end
      bus_write(`LCD_ADDR_LCDC, 8'h00);
   endtask

   //////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////

   initial begin
      error_count = 0;
      lcg_state   = 32'ha3b0;
      reset          <= 1'b1;
      mem_enable     <= 1'b0;
      rd_n           <= 1'b1;
      wr_n           <= 1'b1;
      addr           <= 16'h0000;
      wr_data        <= 8'h00;
      int_vblank_ack <= 1'b0;
      int_lcdc_ack   <= 1'b0;
      repeat (2) @(posedge clock);
      reset <= 1'b0;
      test_registers();
      test_vram();
      test_line_timing();
      test_interrupts();
      test_background();
      $display("errors: %0d", error_count);
      if (error_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/lcd_pkg.sv
common/lcd_regs_if.sv
render/vram.sv
render/bg_fetch.sv
src/lcd_regs.sv
src/lcd_timing.sv
src/lcd_top.sv
tests/lcd_tb.sv

// File: Makefile
TOP = lcd_tb

sim:
	verilator --binary -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
